//--- common/soc_mem_pkg.sv
package soc_mem_pkg;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////
  localparam logic [31:0] RAM_BASE      = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK      = 32'h000F_FFFF;
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = 10;

  ////////////////////////////////////////////////////////////
  // Timing
  ////////////////////////////////////////////////////////////
  // Cycles from first valid to ready for a RAM access
  localparam int MEM_LATENCY = 16;
  localparam int LAT_W       = $clog2(MEM_LATENCY + 1);

  // Short bit period keeps simulation fast
  localparam int CLKS_PER_BIT = 16;
  localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // Program frame start byte
  localparam logic [7:0] PROG_SYNC = 8'hA5;

  ////////////////////////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } iomem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } iomem_rsp_t;

  ////////////////////////////////////////////////////////////
  // State and decode enums
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    REG_RAM,
    REG_TIMER_LO,
    REG_TIMER_HI,
    REG_NONE
  } region_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_CNT_LO,
    LD_CNT_HI,
    LD_DATA
  } ld_state_t;

endpackage

//--- main_memory/byte_ram.sv
module byte_ram
  import soc_mem_pkg::*;
(
  input  logic              clk_used,
  input  logic [3:0]        we_i,
  input  logic [RAM_AW-1:0] addr_i,
  input  logic [31:0]       wdata_i,
  input  logic              re_i,
  output logic [31:0]       rdata_o
);

  logic [31:0] mem [RAM_WORDS];
  logic [31:0] rdata_q;

  ////////////////////////////////////////////////////////////
  // Byte lane writes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_used) begin
    for (int b = 0; b < 4; b++) begin
      if (we_i[b]) begin
        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Registered read, holds last value when idle
  always_ff @(posedge clk_used) begin
    if (re_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- main_memory/uart_rx_prog.sv
module uart_rx_prog
  import soc_mem_pkg::*;
(
  input  logic       clk_used,
  input  logic       rst_n,
  input  logic       rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_byte_o
);

  rx_state_t            state;
  logic [1:0]           rx_sync;
  logic                 rx_s;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shift_q;
  logic                 valid_q;

  // Two flop synchronizer, idles high
  always_ff @(posedge clk_used) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx_i};
    end
  end

  assign rx_s = rx_sync[1];

  ////////////////////////////////////////////////////////////
  // Receive FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_used) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rx_s) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Recheck at mid bit to reject glitches
          if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          // Framing error drops the byte
          if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            valid_q <= rx_s;
            state   <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first, each sample enters at the top
  always_ff @(posedge clk_used) begin
    if (state == RX_DATA && clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

//--- main_memory/prog_loader.sv
module prog_loader
  import soc_mem_pkg::*;
(
  input  logic              clk_used,
  input  logic              rst_n,
  input  logic              rx_valid_i,
  input  logic [7:0]        rx_byte_i,
  output logic              prog_we_o,
  output logic [RAM_AW-1:0] prog_addr_o,
  output logic [31:0]       prog_wdata_o,
  output logic              prog_mode_o,
  output logic              core_rst_n_o
);

  ld_state_t         state;
  logic [15:0]       words_left;
  logic [1:0]        byte_idx;
  logic [31:0]       word_q;
  logic [RAM_AW-1:0] addr_q;
  logic              we_q;
  logic              last_q;
  logic              mode_q;
  logic              run_q;

  ////////////////////////////////////////////////////////////
  // Frame parser
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_used) begin
    if (!rst_n) begin
      state      <= LD_IDLE;
      words_left <= '0;
      byte_idx   <= '0;
      addr_q     <= '0;
      we_q       <= 1'b0;
      last_q     <= 1'b0;
      mode_q     <= 1'b0;
      run_q      <= 1'b0;
    end else begin
      run_q <= 1'b1;
      we_q  <= 1'b0;

      // Advance after each word write, leave program mode after the last
      if (we_q) begin
        addr_q <= addr_q + 1'b1;
        if (last_q) begin
          last_q <= 1'b0;
          mode_q <= 1'b0;
        end
      end

      if (rx_valid_i) begin
        case (state)
          LD_IDLE: begin
            if (rx_byte_i == PROG_SYNC) begin
              state  <= LD_CNT_LO;
              mode_q <= 1'b1;
              addr_q <= '0;
            end
          end
          LD_CNT_LO: begin
            words_left[7:0] <= rx_byte_i;
            state           <= LD_CNT_HI;
          end
          LD_CNT_HI: begin
            words_left[15:8] <= rx_byte_i;
            byte_idx         <= '0;
            if ({rx_byte_i, words_left[7:0]} == 16'd0) begin
              state  <= LD_IDLE;
              mode_q <= 1'b0;
            end else begin
              state <= LD_DATA;
            end
          end
          default: begin
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == 2'd3) begin
              we_q       <= 1'b1;
              words_left <= words_left - 1'b1;
              if (words_left == 16'd1) begin
                last_q <= 1'b1;
                state  <= LD_IDLE;
              end
            end
          end
        endcase
      end
    end
  end

  // Little endian word assembly
  always_ff @(posedge clk_used) begin
    if (rx_valid_i && state == LD_DATA) begin
      word_q <= {rx_byte_i, word_q[31:8]};
    end
  end

  assign prog_we_o    = we_q;
  assign prog_addr_o  = addr_q;
  assign prog_wdata_o = word_q;
  assign prog_mode_o  = mode_q;

  // Core held in reset until the first clock after reset and for a whole frame
  assign core_rst_n_o = run_q & ~mode_q;

endmodule

//--- main_memory/main_memory.sv
module main_memory
  import soc_mem_pkg::*;
(
  input  logic              clk_used,
  input  logic              rst_n,
  input  logic              uart_rx_i,
  input  logic [3:0]        ram_we_i,
  input  logic              ram_re_i,
  input  logic [RAM_AW-1:0] ram_addr_i,
  input  logic [31:0]       ram_wdata_i,
  output logic [31:0]       ram_rdata_o,
  output logic              prog_mode_o,
  output logic              core_rst_n_o
);

  logic              rx_valid;
  logic [7:0]        rx_byte;
  logic              prog_we;
  logic [RAM_AW-1:0] prog_addr;
  logic [31:0]       prog_wdata;
  logic              prog_mode;

  logic [3:0]        mem_we;
  logic [RAM_AW-1:0] mem_addr;
  logic [31:0]       mem_wdata;
  logic              mem_re;

  uart_rx_prog u_rx (
    .clk_used   (clk_used),
    .rst_n      (rst_n),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  prog_loader u_loader (
    .clk_used     (clk_used),
    .rst_n        (rst_n),
    .rx_valid_i   (rx_valid),
    .rx_byte_i    (rx_byte),
    .prog_we_o    (prog_we),
    .prog_addr_o  (prog_addr),
    .prog_wdata_o (prog_wdata),
    .prog_mode_o  (prog_mode),
    .core_rst_n_o (core_rst_n_o)
  );

  // Loader owns the RAM during a frame
  assign mem_we    = prog_mode ? {4{prog_we}} : ram_we_i;
  assign mem_addr  = prog_mode ? prog_addr : ram_addr_i;
  assign mem_wdata = prog_mode ? prog_wdata : ram_wdata_i;
  assign mem_re    = ram_re_i & ~prog_mode;

  byte_ram u_ram (
    .clk_used (clk_used),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .re_i     (mem_re),
    .rdata_o  (ram_rdata_o)
  );

  assign prog_mode_o = prog_mode;

endmodule

//--- rtl/iomem_fabric.sv
module iomem_fabric
  import soc_mem_pkg::*;
(
  input  logic              clk_used,
  input  logic              rst_n,
  input  logic              core_rst_n_i,
  input  iomem_req_t        bus_req_i,
  input  logic [31:0]       ram_rdata_i,
  output iomem_rsp_t        bus_rsp_o,
  output logic [3:0]        ram_we_o,
  output logic              ram_re_o,
  output logic [RAM_AW-1:0] ram_addr_o
);

  region_t          region;
  logic             ram_sel;
  logic             is_read;
  logic             lat_done;
  logic [LAT_W-1:0] lat_cnt;
  logic [63:0]      timer;
  logic [31:0]      rdata;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    if ((bus_req_i.addr & ~RAM_MASK) == RAM_BASE) begin
      region = REG_RAM;
    end else if (bus_req_i.addr == TIMER_LO_ADDR) begin
      region = REG_TIMER_LO;
    end else if (bus_req_i.addr == TIMER_HI_ADDR) begin
      region = REG_TIMER_HI;
    end else begin
      region = REG_NONE;
    end
  end

  assign ram_sel  = bus_req_i.valid & (region == REG_RAM);
  assign is_read  = ~|bus_req_i.wstrb;
  assign lat_done = (lat_cnt == LAT_W'(MEM_LATENCY));

  ////////////////////////////////////////////////////////////
  // RAM latency counter
  ////////////////////////////////////////////////////////////
  // Counts cycles of a pending RAM request, back to zero after ready
  always_ff @(posedge clk_used) begin
    if (!rst_n) begin
      lat_cnt <= '0;
    end else if (ram_sel && !lat_done) begin
      lat_cnt <= lat_cnt + 1'b1;
    end else begin
      lat_cnt <= '0;
    end
  end

  // Write lands with ready
  assign ram_we_o = (ram_sel && lat_done) ? bus_req_i.wstrb : 4'b0000;

  // Read one cycle early so registered data meets ready
  assign ram_re_o   = ram_sel & is_read & (lat_cnt == LAT_W'(MEM_LATENCY - 1));
  assign ram_addr_o = bus_req_i.addr[RAM_AW+1:2];

  ////////////////////////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_used) begin
    if (!rst_n || !core_rst_n_i) begin
      timer <= 64'd0;
    end else begin
      timer <= timer + 64'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (region)
      REG_RAM:      rdata = ram_rdata_i;
      REG_TIMER_LO: rdata = timer[31:0];
      REG_TIMER_HI: rdata = timer[63:32];
      default:      rdata = 32'd0;
    endcase
  end

  // Timer and unmapped answer at once, RAM waits for the counter
  assign bus_rsp_o.ready = bus_req_i.valid & ((region != REG_RAM) | lat_done);
  assign bus_rsp_o.rdata = rdata;

endmodule

//--- rtl/mem_subsys_top.sv
module mem_subsys_top
  import soc_mem_pkg::*;
(
  input  logic       clk_used,
  input  logic       rst_n,
  input  iomem_req_t bus_req_i,
  input  logic       uart_rx_i,
  output iomem_rsp_t bus_rsp_o,
  output logic       prog_mode_o,
  output logic       core_rst_n_o
);

  logic [3:0]        ram_we;
  logic              ram_re;
  logic [RAM_AW-1:0] ram_addr;
  logic [31:0]       ram_rdata;
  logic              core_rst_n;

  ////////////////////////////////////////////////////////////
  // Bus fabric and timer
  ////////////////////////////////////////////////////////////
  iomem_fabric u_fabric (
    .clk_used     (clk_used),
    .rst_n        (rst_n),
    .core_rst_n_i (core_rst_n),
    .bus_req_i    (bus_req_i),
    .ram_rdata_i  (ram_rdata),
    .bus_rsp_o    (bus_rsp_o),
    .ram_we_o     (ram_we),
    .ram_re_o     (ram_re),
    .ram_addr_o   (ram_addr)
  );

  ////////////////////////////////////////////////////////////
  // RAM with UART loader
  ////////////////////////////////////////////////////////////
  main_memory u_mem (
    .clk_used     (clk_used),
    .rst_n        (rst_n),
    .uart_rx_i    (uart_rx_i),
    .ram_we_i     (ram_we),
    .ram_re_i     (ram_re),
    .ram_addr_i   (ram_addr),
    .ram_wdata_i  (bus_req_i.wdata),
    .ram_rdata_o  (ram_rdata),
    .prog_mode_o  (prog_mode_o),
    .core_rst_n_o (core_rst_n)
  );

  assign core_rst_n_o = core_rst_n;

endmodule

//--- tests/mem_subsys_assertions.sv
module mem_subsys_assertions
  import soc_mem_pkg::*;
(
  input logic       clk_used,
  input logic       rst_n,
  input iomem_req_t bus_req_i,
  input iomem_rsp_t bus_rsp_o,
  input logic       prog_mode_o,
  input logic       core_rst_n_o
);

  int unsigned fail_cnt = 0;
  int          pend_cycles;
  logic        ram_req;

  assign ram_req = bus_req_i.valid &&
                   bus_req_i.addr >= RAM_BASE && bus_req_i.addr <= (RAM_BASE | RAM_MASK);

  // Cycles the current request has waited so far
  always_ff @(posedge clk_used) begin
    if (!rst_n) begin
      pend_cycles <= 0;
    end else if (!bus_req_i.valid || bus_rsp_o.ready) begin
      pend_cycles <= 0;
    end else begin
      pend_cycles <= pend_cycles + 1;
    end
  end

  ready_needs_valid: assert property (@(posedge clk_used) disable iff (!rst_n)
    bus_rsp_o.ready |-> bus_req_i.valid)
    else begin
      $error("ready raised without valid");
      fail_cnt++;
    end

  ram_fixed_latency: assert property (@(posedge clk_used) disable iff (!rst_n)
    ram_req |-> (bus_rsp_o.ready == (pend_cycles == MEM_LATENCY)))
    else begin
      $error("RAM ready off its fixed latency");
      fail_cnt++;
    end

  core_held_in_prog: assert property (@(posedge clk_used) disable iff (!rst_n)
    prog_mode_o |-> !core_rst_n_o)
    else begin
      $error("core released during program mode");
      fail_cnt++;
    end

endmodule

bind mem_subsys_top mem_subsys_assertions u_assert (.*);

//--- tests/tb_mem_subsys.sv
module tb_mem_subsys
  import soc_mem_pkg::*;
();

  logic       clk_used;
  logic       rst_n;
  iomem_req_t bus_req;
  iomem_rsp_t bus_rsp;
  logic       uart_rx;
  logic       prog_mode;
  logic       core_rst_n;

  // Reference model state
  logic [31:0]     ram_model [RAM_WORDS];
  longint unsigned cycle_cnt   = 0;
  longint unsigned run_cycles  = 0;
  longint unsigned rsp_cycle   = 0;
  int              wait_cycles = 0;
  integer          seed;
  string           test_name   = "reset";

  mem_subsys_top u_dut (
    .clk_used     (clk_used),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req),
    .uart_rx_i    (uart_rx),
    .bus_rsp_o    (bus_rsp),
    .prog_mode_o  (prog_mode),
    .core_rst_n_o (core_rst_n)
  );

  initial begin
    clk_used = 1'b0;
    forever begin
      #5 clk_used = ~clk_used;
    end
  end

  always @(posedge clk_used) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic region_t decode_region(input logic [31:0] addr);
    if (addr >= RAM_BASE && addr <= (RAM_BASE | RAM_MASK)) begin
      return REG_RAM;
    end else if (addr == TIMER_LO_ADDR) begin
      return REG_TIMER_LO;
    end else if (addr == TIMER_HI_ADDR) begin
      return REG_TIMER_HI;
    end
    return REG_NONE;
  endfunction

  function automatic logic [31:0] ram_word_addr(input logic [RAM_AW-1:0] idx);
    return RAM_BASE + 32'({idx, 2'b00});
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %0h actual %0h", what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_response();
    logic [RAM_AW-1:0] idx;
    logic [31:0]       expected;
    logic              is_write;
    region_t           region;
    idx      = bus_req.addr[RAM_AW+1:2];
    is_write = |bus_req.wstrb;
    region   = decode_region(bus_req.addr);
    expected = 32'd0;
    case (region)
      REG_RAM: begin
        check_value({test_name, ": RAM latency"}, 64'(MEM_LATENCY), 64'(wait_cycles));
        if (is_write) begin
          ram_model[idx] = merge_word(ram_model[idx], bus_req.wdata, bus_req.wstrb);
        end
        expected = ram_model[idx];
      end
      REG_TIMER_LO: expected = run_cycles[31:0];
      REG_TIMER_HI: expected = run_cycles[63:32];
      default:      expected = 32'd0;
    endcase
    if (region != REG_RAM) begin
      check_value({test_name, ": immediate ready"}, 64'd0, 64'(wait_cycles));
    end
    if (!is_write) begin
      check_value({test_name, ": read data"}, 64'(expected), 64'(bus_rsp.rdata));
    end
  endtask

  // Compare process, sampled mid cycle where the bus is stable
  always @(negedge clk_used) begin
    if (rst_n === 1'b1 && bus_req.valid) begin
      if (bus_rsp.ready) begin
        check_response();
        wait_cycles = 0;
      end else begin
        wait_cycles++;
      end
    end
    // Timer model restarts while the core is held in reset
    if (core_rst_n === 1'b1) begin
      run_cycles++;
    end else begin
      run_cycles = 0;
    end
  end

  // Bound assertion failures end the run at once
  always @(negedge clk_used) begin
    if (u_dut.u_assert.fail_cnt != 0) begin
      $display("Bound assertion failed in test %s", test_name);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////
  // Entered and left 1 time unit after a rising edge
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited        = 0;
    bus_req.addr  = addr;
    bus_req.wstrb = strb;
    bus_req.wdata = wdata;
    bus_req.valid = 1'b1;
    @(negedge clk_used);
    while (bus_rsp.ready !== 1'b1) begin
      waited++;
      if (waited > 4 * MEM_LATENCY) begin
        timeout_fail($sformatf("no ready for bus address %h", addr));
      end
      @(negedge clk_used);
    end
    rdata     = bus_rsp.rdata;
    rsp_cycle = cycle_cnt;
    @(posedge clk_used);
    #1;
    bus_req = '0;
  endtask

  // 8N1, start bit first
  task automatic uart_send(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk_used);
      #1;
    end
  endtask

  task automatic wait_prog_mode(input logic level);
    int waited;
    waited = 0;
    while (prog_mode !== level) begin
      waited++;
      if (waited > 20 * CLKS_PER_BIT) begin
        timeout_fail("prog_mode_o never reached the expected level");
      end
      @(posedge clk_used);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0]       rd;
    logic [31:0]       wdata;
    logic [31:0]       t1;
    logic [31:0]       t2;
    longint unsigned   c1;
    logic [3:0]        strb;
    logic [RAM_AW-1:0] idx;
    logic [31:0]       prog_words [4];

    seed    = 32'h6a34_29b9;
    rst_n   = 1'b0;
    bus_req = '0;
    uart_rx = 1'b1;
    repeat (10) @(posedge clk_used);
    #1;
    rst_n = 1'b1;
    @(posedge clk_used);
    #1;
    check_value("reset: ready", 64'd0, 64'(bus_rsp.ready));
    check_value("reset: prog_mode_o", 64'd0, 64'(prog_mode));
    check_value("reset: core_rst_n_o", 64'd1, 64'(core_rst_n));

    // Full word first, then a partial strobe over it
    test_name = "ram";
    idx       = '0;
    for (int i = 0; i < 12; i++) begin
      wdata = $random(seed);
      idx   = wdata[RAM_AW-1:0];
      wdata = $random(seed);
      bus_access(ram_word_addr(idx), 4'hF, wdata, rd);
      wdata = $random(seed);
      strb  = wdata[3:0];
      wdata = $random(seed);
      bus_access(ram_word_addr(idx), strb, wdata, rd);
      bus_access(ram_word_addr(idx), 4'h0, 32'd0, rd);
    end

    test_name = "timer";
    bus_access(TIMER_LO_ADDR, 4'h0, 32'd0, t1);
    c1 = rsp_cycle;
    repeat (23) @(posedge clk_used);
    #1;
    bus_access(TIMER_LO_ADDR, 4'h0, 32'd0, t2);
    t2 = t2 - t1;
    check_value("timer: low word delta", rsp_cycle - c1, 64'(t2));
    bus_access(TIMER_HI_ADDR, 4'h0, 32'd0, rd);
    check_value("timer: high word", 64'd0, 64'(rd));

    // Same low address bits as a RAM word already written
    test_name = "unmapped";
    bus_access(32'h2000_0000, 4'h0, 32'd0, rd);
    bus_access(32'h2000_0000 + 32'({idx, 2'b00}), 4'hF, 32'hDEAD_BEEF, rd);
    bus_access(ram_word_addr(idx), 4'h0, 32'd0, rd);

    test_name = "program";
    for (int w = 0; w < 4; w++) begin
      prog_words[w] = $random(seed);
    end
    uart_send(PROG_SYNC);
    uart_send(8'd4);
    uart_send(8'd0);
    check_value("program: prog_mode_o in frame", 64'd1, 64'(prog_mode));
    check_value("program: core_rst_n_o in frame", 64'd0, 64'(core_rst_n));
    for (int w = 0; w < 4; w++) begin
      for (int b = 0; b < 4; b++) begin
        uart_send(prog_words[w][b*8 +: 8]);
      end
    end
    wait_prog_mode(1'b0);
    check_value("program: core_rst_n_o after frame", 64'd1, 64'(core_rst_n));
    for (int w = 0; w < 4; w++) begin
      ram_model[w] = prog_words[w];
    end
    for (int w = 0; w < 4; w++) begin
      bus_access(ram_word_addr(RAM_AW'(w)), 4'h0, 32'd0, rd);
    end
    bus_access(TIMER_LO_ADDR, 4'h0, 32'd0, rd);

    if (u_dut.u_assert.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", u_dut.u_assert.fail_cnt);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

//--- filelist.f
common/soc_mem_pkg.sv
main_memory/byte_ram.sv
main_memory/uart_rx_prog.sv
main_memory/prog_loader.sv
main_memory/main_memory.sv
rtl/iomem_fabric.sv
rtl/mem_subsys_top.sv
tests/mem_subsys_assertions.sv
tests/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsys -f filelist.f

output=$(./obj_dir/Vtb_mem_subsys +verilator+error+limit+100 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
